/* filelist.f */
source/snac_pkg.sv
source/snac_strobe_gen.sv
source/snac_mode_ctrl.sv
source/serlatch_reader.sv
source/pce_reader.sv
source/snac_port_mux.sv
source/snac_adapter_top.sv
verification/snac_pad_model.sv
verification/snac_tb.sv

/* source/pce_reader.sv */
// PC Engine pad reader
`timescale 1ns/10ps

module pce_reader
    import snac_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_clear,
    input  logic       i_enable,
    input  logic       i_stb,
    input  logic [3:0] i_dat,
    output logic       o_clr,
    output logic       o_sel,
    output btn_word_t  o_p1,
    output logic       o_busy
);

    typedef enum logic [1:0] {
        PCE_IDLE,
        PCE_CLR,
        PCE_DIR,
        PCE_BTN
    } pce_state_t;

    pce_state_t state;
    logic       stb_en;
    logic [3:0] dir_q;
    btn_word_t  word;

    assign stb_en = i_stb & i_enable;

    // directions from the first nibble, buttons from the live one
    // upper byte unused by a 2-button pad
    always_comb begin
        word                 = '0;
        word[PCE_BIT_UP]     = dir_q[0];
        word[PCE_BIT_RIGHT]  = dir_q[1];
        word[PCE_BIT_DOWN]   = dir_q[2];
        word[PCE_BIT_LEFT]   = dir_q[3];
        word[PCE_BIT_I]      = ~i_dat[0];
        word[PCE_BIT_II]     = ~i_dat[1];
        word[PCE_BIT_SELECT] = ~i_dat[2];
        word[PCE_BIT_RUN]    = ~i_dat[3];
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state  <= PCE_IDLE;
            dir_q  <= '0;
            o_p1   <= '0;
            o_busy <= 1'b0;
        end else if (i_clear) begin
            state  <= PCE_IDLE;
            dir_q  <= '0;
            o_p1   <= '0;
            o_busy <= 1'b0;
        end else begin
            case (state)
                PCE_IDLE: begin
                    o_busy <= 1'b0;
                    if (stb_en) begin
                        o_busy <= 1'b1;
                        state  <= PCE_CLR;
                    end
                end
                PCE_CLR: begin
                    // clr pulse resets the pad nibble selector
                    if (stb_en) begin
                        state <= PCE_DIR;
                    end
                end
                PCE_DIR: begin
                    // sel high, pad shows the d-pad
                    if (stb_en) begin
                        dir_q <= ~i_dat;
                        state <= PCE_BTN;
                    end
                end
                PCE_BTN: begin
                    // sel low, pad shows I, II, select, run
                    // sel goes back high as the word is written
                    if (stb_en) begin
                        o_p1  <= word;
                        state <= PCE_IDLE;
                    end
                end
                default: state <= PCE_IDLE;
            endcase
        end
    end

    assign o_clr = (state == PCE_CLR);
    // sel rests high only while this family owns the pins
    assign o_sel = i_enable & (state != PCE_BTN);

endmodule

/* source/serlatch_reader.sv */
// Serial latch pad reader
`timescale 1ns/10ps

module serlatch_reader
    import snac_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_clear,
    input  logic      i_enable,
    input  gc_type_t  i_mode,
    input  logic      i_stb,
    input  logic      i_dat1,
    input  logic      i_dat2,
    output logic      o_clk,
    output logic      o_clk2,
    output logic      o_lat,
    output btn_word_t o_p1,
    output btn_word_t o_p2,
    output logic      o_busy
);

    typedef enum logic [2:0] {
        SL_IDLE,
        SL_LATCH,
        SL_CLK_LOW,
        SL_CLK_HIGH,
        SL_DONE
    } sl_state_t;

    sl_state_t state;
    logic      stb_en;
    logic [3:0] bit_idx;
    logic [3:0] bit_last;
    btn_word_t cap1;
    btn_word_t cap2;

    // strobes are ignored while another family owns the pins
    assign stb_en = i_stb & i_enable;

    // index of the last bit for this pad type
    always_comb begin
        case (i_mode)
            GC_NES:  bit_last = 4'(SL_BITS_NES - 1);
            GC_SNES: bit_last = 4'(SL_BITS_SNES - 1);
            default: bit_last = 4'(SL_BITS_DB15 - 1);
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= SL_IDLE;
            bit_idx <= '0;
            cap1    <= '0;
            cap2    <= '0;
            o_p1    <= '0;
            o_p2    <= '0;
            o_busy  <= 1'b0;
        end else if (i_clear) begin
            state   <= SL_IDLE;
            bit_idx <= '0;
            cap1    <= '0;
            cap2    <= '0;
            o_p1    <= '0;
            o_p2    <= '0;
            o_busy  <= 1'b0;
        end else begin
            case (state)
                SL_IDLE: begin
                    // busy drops one cycle after the words land
                    o_busy <= 1'b0;
                    if (stb_en) begin
                        o_busy  <= 1'b1;
                        cap1    <= '0;
                        cap2    <= '0;
                        bit_idx <= '0;
                        state   <= SL_LATCH;
                    end
                end
                SL_LATCH: begin
                    if (stb_en) begin
                        state <= SL_CLK_LOW;
                    end
                end
                SL_CLK_LOW: begin
                    // sample on the strobe that raises the clock
                    // pads pull low for a pressed button
                    if (stb_en) begin
                        cap1[bit_idx] <= ~i_dat1;
                        cap2[bit_idx] <= ~i_dat2;
                        state         <= SL_CLK_HIGH;
                    end
                end
                SL_CLK_HIGH: begin
                    if (stb_en) begin
                        if (bit_idx == bit_last) begin
                            state <= SL_DONE;
                        end else begin
                            bit_idx <= bit_idx + 4'd1;
                            state   <= SL_CLK_LOW;
                        end
                    end
                end
                SL_DONE: begin
                    // both players update on the same edge
                    if (stb_en) begin
                        o_p1  <= cap1;
                        o_p2  <= cap2;
                        state <= SL_IDLE;
                    end
                end
                default: state <= SL_IDLE;
            endcase
        end
    end

    // clock idles low, so the only rising edges are bit shifts
    assign o_lat  = (state == SL_LATCH);
    assign o_clk  = (state == SL_CLK_HIGH);
    // second clock line for player 2 wiring
    assign o_clk2 = o_clk;

endmodule

/* source/snac_adapter_top.sv */
// SNAC adapter top level
`timescale 1ns/10ps

module snac_adapter_top
    import snac_pkg::*;
#(
    parameter int unsigned CLK_FREQ_HZ = 50_000_000
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  gc_type_t   i_game_cont_type,
    output btn_word_t  o_p1_btn_state,
    output btn_word_t  o_p2_btn_state,
    output logic       o_busy,
    output logic       o_cart_bk0_dir,
    input  logic [7:4] i_cart_bk0_in,
    output logic [7:6] o_cart_bk1_out_p76,
    output logic       o_cart_pin30_out,
    output logic       o_cart_pin30_dir,
    input  logic       i_cart_pin31_in,
    output logic       o_cart_pin31_dir
);

    gc_type_t   mode;
    gc_family_t family;
    step_t      step;
    logic       scan_clear;
    logic       stb;
    snac_in_t   pads;
    // serial reader lines
    logic       sl_clk;
    logic       sl_clk2;
    logic       sl_lat;
    btn_word_t  sl_p1;
    btn_word_t  sl_p2;
    logic       sl_busy;
    // pc engine reader lines
    logic       pce_clr;
    logic       pce_sel;
    btn_word_t  pce_p1;
    logic       pce_busy;
    snac_out_t  sl_out;
    snac_out_t  pce_out;

    // pin roles per reader, io5 unused by the pc engine pad
    assign sl_out  = '{out1: sl_clk, out2: sl_lat, io5: sl_clk2};
    assign pce_out = '{out1: pce_clr, out2: pce_sel, io5: 1'b0};

    snac_mode_ctrl #(
        .CLK_FREQ_HZ(CLK_FREQ_HZ)
    ) mode_ctrl_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_game_cont_type(i_game_cont_type),
        .o_mode(mode), .o_family(family), .o_step(step), .o_scan_clear(scan_clear)
    );

    snac_strobe_gen strobe_gen_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_clear(scan_clear),
        .i_step(step), .o_stb(stb)
    );

    // DB15, NES and SNES share the latch reader
    serlatch_reader serlatch_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_clear(scan_clear),
        .i_enable(family == FAM_SERLATCH), .i_mode(mode), .i_stb(stb),
        .i_dat1(pads.io3), .i_dat2(pads.in7),
        .o_clk(sl_clk), .o_clk2(sl_clk2), .o_lat(sl_lat),
        .o_p1(sl_p1), .o_p2(sl_p2), .o_busy(sl_busy)
    );

    // data nibble D3..D0 = in7, io3, io6, in4
    pce_reader pce_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_clear(scan_clear),
        .i_enable(family == FAM_PCE), .i_stb(stb),
        .i_dat({pads.in7, pads.io3, pads.io6, pads.in4}),
        .o_clr(pce_clr), .o_sel(pce_sel), .o_p1(pce_p1), .o_busy(pce_busy)
    );

    snac_port_mux port_mux_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_family(family),
        .i_sl_out(sl_out), .i_pce_out(pce_out),
        .i_sl_p1(sl_p1), .i_sl_p2(sl_p2), .i_pce_p1(pce_p1),
        .i_sl_busy(sl_busy), .i_pce_busy(pce_busy),
        .i_cart_bk0_in(i_cart_bk0_in), .i_cart_pin31_in(i_cart_pin31_in),
        .o_pads(pads), .o_p1(o_p1_btn_state), .o_p2(o_p2_btn_state), .o_busy(o_busy),
        .o_cart_bk0_dir(o_cart_bk0_dir), .o_cart_bk1_out_p76(o_cart_bk1_out_p76),
        .o_cart_pin30_out(o_cart_pin30_out), .o_cart_pin30_dir(o_cart_pin30_dir),
        .o_cart_pin31_dir(o_cart_pin31_dir)
    );

endmodule

/* source/snac_mode_ctrl.sv */
// Controller mode decode
`timescale 1ns/10ps

module snac_mode_ctrl
    import snac_pkg::*;
#(
    parameter int unsigned CLK_FREQ_HZ = 50_000_000
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  gc_type_t   i_game_cont_type,
    output gc_type_t   o_mode,
    output gc_family_t o_family,
    output step_t      o_step,
    output logic       o_scan_clear
);

    // strobe steps for each supported rate
    localparam step_t STEP_SL_NORMAL = calc_step(CLK_FREQ_HZ, POLL_SERLATCH_NORMAL);
    localparam step_t STEP_SL_FAST   = calc_step(CLK_FREQ_HZ, POLL_SERLATCH_FAST);
    localparam step_t STEP_SNES      = calc_step(CLK_FREQ_HZ, POLL_SNES_COMPAT);
    localparam step_t STEP_PCE       = calc_step(CLK_FREQ_HZ, POLL_PCE_NORMAL);

    gc_type_t type_legal;
    gc_type_t mode_q;
    logic     clear_q;

    // anything not supported falls back to disabled
    always_comb begin
        case (i_game_cont_type)
            GC_DB15, GC_DB15_FAST, GC_NES, GC_SNES, GC_PCE_2BTN: type_legal = i_game_cont_type;
            default: type_legal = GC_DISABLED;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mode_q  <= GC_DISABLED;
            clear_q <= 1'b0;
        end else begin
            mode_q  <= type_legal;
            // high together with the new mode, for one cycle
            clear_q <= (type_legal != mode_q);
        end
    end

    // reader family and strobe rate per mode
    always_comb begin
        o_family = FAM_NONE;
        o_step   = '0;
        case (mode_q)
            GC_DB15: begin
                o_family = FAM_SERLATCH;
                o_step   = STEP_SL_NORMAL;
            end
            GC_DB15_FAST: begin
                o_family = FAM_SERLATCH;
                o_step   = STEP_SL_FAST;
            end
            GC_NES, GC_SNES: begin
                o_family = FAM_SERLATCH;
                o_step   = STEP_SNES;
            end
            GC_PCE_2BTN: begin
                o_family = FAM_PCE;
                o_step   = STEP_PCE;
            end
            default: begin
                o_family = FAM_NONE;
                o_step   = '0;
            end
        endcase
    end

    assign o_mode       = mode_q;
    assign o_scan_clear = clear_q;

endmodule

/* source/snac_pkg.sv */
// SNAC adapter shared definitions
package snac_pkg;

    // one player's pressed buttons, active high
    typedef logic [15:0] btn_word_t;

    // phase increment of the strobe accumulator
    typedef logic [31:0] step_t;

    // controller codes as seen on the settings pins
    typedef enum logic [4:0] {
        GC_DISABLED  = 5'd0,
        GC_DB15      = 5'd1,
        GC_NES       = 5'd2,
        GC_SNES      = 5'd3,
        GC_PCE_2BTN  = 5'd4,
        GC_DB15_FAST = 5'd9
    } gc_type_t;

    // which reader owns the pins
    typedef enum logic [1:0] {
        FAM_NONE,
        FAM_SERLATCH,
        FAM_PCE
    } gc_family_t;

    // sampled pad lines, configuration A
    typedef struct packed {
        logic in4;
        logic io3;
        logic io6;
        logic in7;
    } snac_in_t;

    // lines driven by the active reader
    typedef struct packed {
        logic out1;
        logic out2;
        logic io5;
    } snac_out_t;

    // polling rates in Hz, the strobe runs at twice these
    localparam int unsigned POLL_SERLATCH_NORMAL = 200_000;
    localparam int unsigned POLL_SERLATCH_FAST   = 400_000;
    localparam int unsigned POLL_SNES_COMPAT     = 50_000;
    localparam int unsigned POLL_PCE_NORMAL      = 40_000;

    // serial bits clocked out per scan
    localparam int SL_BITS_NES  = 8;
    localparam int SL_BITS_SNES = 16;
    localparam int SL_BITS_DB15 = 16;

    // pc engine button positions in btn_word_t
    localparam int PCE_BIT_UP     = 0;
    localparam int PCE_BIT_RIGHT  = 1;
    localparam int PCE_BIT_DOWN   = 2;
    localparam int PCE_BIT_LEFT   = 3;
    localparam int PCE_BIT_I      = 4;
    localparam int PCE_BIT_II     = 5;
    localparam int PCE_BIT_SELECT = 6;
    localparam int PCE_BIT_RUN    = 7;

    // step = 2^32 * 2 * poll / clk, rounded down
    function automatic step_t calc_step(input longint unsigned clk_hz,
                                        input longint unsigned poll_hz);
        longint unsigned num;
        num = (64'd1 << 33) * poll_hz;
        return step_t'(num / clk_hz);
    endfunction

endpackage

/* source/snac_port_mux.sv */
// Cartridge port pin mux
`timescale 1ns/10ps

module snac_port_mux
    import snac_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  gc_family_t i_family,
    input  snac_out_t  i_sl_out,
    input  snac_out_t  i_pce_out,
    input  btn_word_t  i_sl_p1,
    input  btn_word_t  i_sl_p2,
    input  btn_word_t  i_pce_p1,
    input  logic       i_sl_busy,
    input  logic       i_pce_busy,
    input  logic [7:4] i_cart_bk0_in,
    input  logic       i_cart_pin31_in,
    output snac_in_t   o_pads,
    output btn_word_t  o_p1,
    output btn_word_t  o_p2,
    output logic       o_busy,
    output logic       o_cart_bk0_dir,
    output logic [7:6] o_cart_bk1_out_p76,
    output logic       o_cart_pin30_out,
    output logic       o_cart_pin30_dir,
    output logic       o_cart_pin31_dir
);

    snac_out_t out_sel;
    snac_out_t out_q;

    // active reader by family, idle lines low otherwise
    always_comb begin
        case (i_family)
            FAM_SERLATCH: begin
                out_sel = i_sl_out;
                o_p1    = i_sl_p1;
                o_p2    = i_sl_p2;
                o_busy  = i_sl_busy;
            end
            FAM_PCE: begin
                out_sel = i_pce_out;
                o_p1    = i_pce_p1;
                o_p2    = '0;
                o_busy  = i_pce_busy;
            end
            default: begin
                out_sel = '0;
                o_p1    = '0;
                o_p2    = '0;
                o_busy  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pads <= '0;
            out_q  <= '0;
        end else begin
            // one sample register for both readers
            o_pads <= '{in4: i_cart_bk0_in[7], io3: i_cart_bk0_in[4],
                        io6: i_cart_pin31_in, in7: i_cart_bk0_in[5]};
            out_q  <= out_sel;
        end
    end

    // configuration A: bank1[7:6] = out2, out1 and pin30 = io5
    assign o_cart_bk1_out_p76 = {out_q.out2, out_q.out1};
    assign o_cart_pin30_out   = out_q.io5;
    // bank0 and pin31 are inputs, pin30 an output
    assign o_cart_bk0_dir     = 1'b0;
    assign o_cart_pin30_dir   = 1'b1;
    assign o_cart_pin31_dir   = 1'b0;

endmodule

/* source/snac_strobe_gen.sv */
// Fractional strobe generator
`timescale 1ns/10ps

module snac_strobe_gen
    import snac_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_clear,
    input  step_t i_step,
    output logic  o_stb
);

    // bit 32 holds the carry of the last add
    logic [32:0] phase;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase <= '0;
        end else if (i_clear) begin
            // restart the phase on a mode change
            phase <= '0;
        end else begin
            // carry is dropped before the next add
            phase <= {1'b0, phase[31:0]} + {1'b0, i_step};
        end
    end

    // one cycle high after each wrap
    // a zero step never wraps
    assign o_stb = phase[32];

endmodule

/* verification/snac_pad_model.sv */
// SNAC pad models
`timescale 1ns/10ps

module snac_pad_model (
    input  logic        i_pce_mode,
    input  logic [15:0] i_p1_word,
    input  logic [15:0] i_p2_word,
    input  logic [7:6]  i_bk1_out,
    input  logic        i_pin30_out,
    output logic [7:4]  o_bk0_in,
    output logic        o_pin31_in
);

    logic [15:0] sr1;
    logic [15:0] sr2;
    logic        lat;
    logic        clk1;
    logic        clk2;
    logic        sel;
    // PC Engine data nibble D3..D0
    logic [3:0]  nib;

    // configuration A roles of the driven lines
    assign lat  = i_bk1_out[7];
    assign clk1 = i_bk1_out[6];
    assign clk2 = i_pin30_out;
    assign sel  = i_bk1_out[7];

    initial begin
        sr1 <= '0;
        sr2 <= '0;
    end

    // latch loads the word
    // each clock rise moves to the next bit
    always @(posedge lat or posedge clk1) begin
        if (lat) begin
            sr1 <= i_p1_word;
        end else begin
            sr1 <= sr1 >> 1;
        end
    end

    // player 2 follows the second clock line
    always @(posedge lat or posedge clk2) begin
        if (lat) begin
            sr2 <= i_p2_word;
        end else begin
            sr2 <= sr2 >> 1;
        end
    end

    // sel high shows the d-pad and sel low the buttons
    // pressed buttons pull the line low
    assign nib = sel ? ~i_p1_word[3:0] : ~i_p1_word[7:4];

    always_comb begin
        if (i_pce_mode) begin
            // D0 in4, D1 io6, D2 io3, D3 in7
            o_bk0_in[7] = nib[0];
            o_bk0_in[6] = 1'b1;
            o_bk0_in[5] = nib[3];
            o_bk0_in[4] = nib[2];
            o_pin31_in  = nib[1];
        end else begin
            o_bk0_in[7] = 1'b1;
            o_bk0_in[6] = 1'b1;
            o_bk0_in[5] = ~sr2[0];
            o_bk0_in[4] = ~sr1[0];
            o_pin31_in  = 1'b1;
        end
    end

endmodule

/* verification/snac_tb.sv */
// SNAC adapter testbench
`timescale 1ns/10ps

module snac_tb
    import snac_pkg::*;
();

    logic       clk;
    logic       rst_n;
    gc_type_t   cont_type;
    btn_word_t  p1_word;
    btn_word_t  p2_word;
    logic       pce_mode;
    btn_word_t  p1_btn;
    btn_word_t  p2_btn;
    logic       busy;
    logic       bk0_dir;
    logic [7:4] bk0_in;
    logic [7:6] bk1_out;
    logic       pin30_out;
    logic       pin30_dir;
    logic       pin31_in;
    logic       pin31_dir;
    logic [15:0] lfsr_q;
    int         checks;
    int         errors;
    int         timeouts;
    int         cyc_db15;
    int         cyc_fast;
    int         cyc_other;

    snac_adapter_top #(
        .CLK_FREQ_HZ(25_000_000)
    ) dut_i (
        .i_clk(clk), .i_rst_n(rst_n), .i_game_cont_type(cont_type),
        .o_p1_btn_state(p1_btn), .o_p2_btn_state(p2_btn), .o_busy(busy),
        .o_cart_bk0_dir(bk0_dir), .i_cart_bk0_in(bk0_in),
        .o_cart_bk1_out_p76(bk1_out), .o_cart_pin30_out(pin30_out),
        .o_cart_pin30_dir(pin30_dir), .i_cart_pin31_in(pin31_in),
        .o_cart_pin31_dir(pin31_dir)
    );

    snac_pad_model pad_i (
        .i_pce_mode(pce_mode), .i_p1_word(p1_word), .i_p2_word(p2_word),
        .i_bk1_out(bk1_out), .i_pin30_out(pin30_out),
        .o_bk0_in(bk0_in), .o_pin31_in(pin31_in)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps of x^16 + x^14 + x^13 + x^11 + 1
    // one step per bit taken
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    // at least one button held so a cleared word stands out
    function automatic btn_word_t rand_word();
        btn_word_t w;
        int        i;
        for (i = 0; i < 16; i++) begin
            w[i] = lfsr_bit();
        end
        if (w == '0) begin
            w = 16'h0001;
        end
        return w;
    endfunction

    task automatic check_val(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t: %s got %04h expected %04h", $time, what, got, exp);
        end
    endtask

    // polls o_busy on falling edges up to limit cycles
    task automatic wait_busy(input logic level, input int limit, output int cycles);
        cycles = 0;
        while (busy !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (busy !== level) begin
            timeouts++;
            $display("timeout: o_busy did not reach %0b within %0d cycles", level, limit);
        end
    endtask

    // waits out one full scan and returns its length in cycles
    task automatic run_scan(output int cycles);
        int dummy;
        wait_busy(1'b1, 2000, dummy);
        wait_busy(1'b0, 20000, cycles);
    endtask

    // new type registers in one cycle and the clear pulse follows
    task automatic set_type(input gc_type_t t);
        @(negedge clk);
        cont_type = t;
        repeat (3) @(negedge clk);
    endtask

    task automatic test_reset_state();
        check_val("reset p1", p1_btn, '0);
        check_val("reset p2", p2_btn, '0);
        check_val("reset busy", 16'(busy), '0);
        check_val("reset bank1 out", 16'(bk1_out), '0);
        check_val("reset pin30 out", 16'(pin30_out), '0);
        check_val("bank0 dir", 16'(bk0_dir), 16'd0);
        check_val("pin30 dir", 16'(pin30_dir), 16'd1);
        check_val("pin31 dir", 16'(pin31_dir), 16'd0);
    endtask

    // NES keeps only 8 bits and the others a full 16
    task automatic test_serial(input gc_type_t t, input logic [15:0] mask,
                               output int cycles);
        @(negedge clk);
        p1_word  = rand_word();
        p2_word  = rand_word();
        pce_mode = 1'b0;
        set_type(t);
        run_scan(cycles);
        check_val({t.name(), " p1"}, p1_btn, p1_word & mask);
        check_val({t.name(), " p2"}, p2_btn, p2_word & mask);
    endtask

    task automatic test_pce();
        @(negedge clk);
        p1_word  = rand_word();
        p2_word  = rand_word();
        pce_mode = 1'b1;
        set_type(GC_PCE_2BTN);
        run_scan(cyc_other);
        check_val("PCE p1", p1_btn, p1_word & 16'h00FF);
        check_val("PCE p2", p2_btn, 16'h0000);
    endtask

    task automatic test_mode_switch();
        int cyc;
        test_serial(GC_DB15, 16'hFFFF, cyc);
        // catch the next scan while it runs
        wait_busy(1'b1, 2000, cyc);
        @(negedge clk);
        p1_word = rand_word();
        p2_word = rand_word();
        set_type(GC_NES);
        check_val("switch p1 cleared", p1_btn, '0);
        check_val("switch p2 cleared", p2_btn, '0);
        check_val("switch busy cleared", 16'(busy), '0);
        run_scan(cyc);
        check_val("after switch p1", p1_btn, p1_word & 16'h00FF);
        check_val("after switch p2", p2_btn, p2_word & 16'h00FF);
    endtask

    // no strobe may start a scan within several PCE strobe periods
    task automatic watch_idle(input string what, input int window);
        int i;
        int start_err;
        start_err = errors;
        for (i = 0; i < window && errors == start_err; i++) begin
            @(negedge clk);
            check_val({what, " p1"}, p1_btn, '0);
            check_val({what, " p2"}, p2_btn, '0);
            check_val({what, " busy and outputs"}, {12'd0, busy, bk1_out, pin30_out}, '0);
        end
    endtask

    task automatic test_disabled();
        set_type(GC_DISABLED);
        watch_idle("disabled", 1500);
        set_type(gc_type_t'(5'd7));
        watch_idle("unknown type", 1500);
    endtask

    initial begin
        rst_n     = 1'b0;
        cont_type = GC_DISABLED;
        p1_word   = '0;
        p2_word   = '0;
        pce_mode  = 1'b0;
        lfsr_q    = 16'd82;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_serial(GC_NES, 16'h00FF, cyc_other);
        test_serial(GC_SNES, 16'hFFFF, cyc_other);
        test_serial(GC_DB15, 16'hFFFF, cyc_db15);
        test_serial(GC_DB15_FAST, 16'hFFFF, cyc_fast);
        checks++;
        assert (cyc_fast < cyc_db15) else begin
            errors++;
            $display("FAILED at %0t: DB15 fast scan %0d cycles, DB15 scan %0d cycles",
                     $time, cyc_fast, cyc_db15);
        end
        test_pce();
        test_mode_switch();
        test_disabled();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
